// File: src/iosys_pkg.sv
// shared widths, address map and register offsets for the io subsystem
// plus the ram request and apb structs
package iosys_pkg;

    typedef logic [31:0] word_t;      // apb and ram data
    typedef logic [22:0] ram_addr_t;  // 8 MB ram byte address
    typedef logic [7:0]  byte_t;      // flash or rom byte
    typedef logic [3:0]  wstrb_t;     // byte lane strobes
    typedef logic [11:0] joy_t;       // buttons of one pad

    // address map
    localparam word_t RAM_TOP  = 32'h0080_0000;  // apb ram window ends here
    localparam word_t REG_BASE = 32'h0200_0000;

    // register offsets from REG_BASE
    localparam word_t OFF_OVERLAY  = 32'h0000_0000;  // text overlay on/off
    localparam word_t OFF_ROM_CTRL = 32'h0000_0030;
    localparam word_t OFF_ROM_DATA = 32'h0000_0034;  // one write streams 4 bytes
    localparam word_t OFF_JOY      = 32'h0000_0040;
    localparam word_t OFF_TIME     = 32'h0000_0050;  // milliseconds since reset
    localparam word_t OFF_CYCLE    = 32'h0000_0054;
    localparam word_t OFF_ID       = 32'h0000_0060;

    localparam logic [15:0] CORE_ID = 16'd2;

    // sizes, scaled down for simulation
    localparam int BOOT_LEN     = 64;   // firmware image bytes
    localparam int TICKS_PER_MS = 100;  // clock cycles per millisecond
    localparam int TICK_W       = $clog2(TICKS_PER_MS);

    // rom streamer runs 4 bytes of 4 phases each
    localparam logic [3:0] ROM_LAST_PHASE = 4'd15;

    // ram request, wstrb of zero is a read
    typedef struct packed {
        logic      valid;
        ram_addr_t addr;
        word_t     wdata;
        wstrb_t    wstrb;
    } mem_req_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apb_rsp_t;

endpackage

// File: src/uptime_timer.sv
`timescale 1ns/1ps
// free-running cycle counter and millisecond counter with prescaler
module uptime_timer import iosys_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    output word_t cycle_count,
    output word_t ms_count
);

    logic [TICK_W-1:0] tick_cnt;  // cycles into the current millisecond

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cycle_count <= '0;
            ms_count    <= '0;
            tick_cnt    <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (tick_cnt == TICK_W'(TICKS_PER_MS - 1)) begin
                tick_cnt <= '0;
                ms_count <= ms_count + 1'b1;  // wraps after ~49 days at real rate
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/rom_streamer.sv
`timescale 1ns/1ps
// rom streamer, sends a 32-bit word to the console core as four byte strobes
// least significant byte first
module rom_streamer import iosys_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  word_t rom_word,
    input  logic  rom_word_we,
    output byte_t rom_byte,
    output logic  rom_valid,
    output logic  rom_busy
);

    // each byte takes 4 phases: 2 with valid high, 2 with valid low
    // phase[3:2] is the byte index, phase[1:0] the position within the byte
    word_t      shift_q;
    logic [3:0] phase;
    logic       busy_q;

    assign rom_byte  = shift_q[7:0];
    assign rom_valid = busy_q && !phase[1];  // phases 0 and 1 of each byte
    assign rom_busy  = busy_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            phase  <= '0;
        end else if (rom_word_we) begin
            busy_q <= 1'b1;
            phase  <= '0;
        end else if (busy_q) begin
            phase <= phase + 1'b1;  // wraps back to 0 after the last phase
            if (phase == ROM_LAST_PHASE)
                busy_q <= 1'b0;     // 16 cycles busy in total
        end
    end

    // next byte moves down at the end of each low gap
    always_ff @(posedge clk) begin
        if (rom_word_we)
            shift_q <= rom_word;
        else if (busy_q && phase[1:0] == 2'd3)
            shift_q <= {8'h00, shift_q[31:8]};
    end

endmodule

// File: src/boot_copier.sv
`timescale 1ns/1ps
// boot copier, moves the firmware image from the flash byte stream into ram
// as one single-lane write per byte
module boot_copier import iosys_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     ram_busy,     // ram still initialising
    input  byte_t    flash_byte,
    input  logic     flash_valid,
    input  logic     boot_ready,   // ram ack for boot_req
    output logic     flash_ready,
    output mem_req_t boot_req,
    output logic     boot_done
);

    typedef enum logic [1:0] {
        BOOT_WAIT,  // waiting for ram to come up
        BOOT_COPY,
        BOOT_DONE
    } boot_state_t;

    boot_state_t state;
    ram_addr_t   next_addr;  // address of the next flash byte
    logic        req_valid;
    ram_addr_t   req_addr;
    word_t       req_wdata;
    wstrb_t      req_wstrb;
    logic        take;
    logic        ack;

    // one write in flight at a time
    assign flash_ready = (state == BOOT_COPY) && !req_valid && !ram_busy;
    assign take        = flash_valid && flash_ready;
    assign ack         = req_valid && boot_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= BOOT_WAIT;
            next_addr <= '0;
            req_valid <= 1'b0;
        end else begin
            case (state)
                BOOT_WAIT: begin
                    if (!ram_busy)
                        state <= BOOT_COPY;
                end
                BOOT_COPY: begin
                    // last byte acknowledged
                    if (ack && req_addr == ram_addr_t'(BOOT_LEN - 1))
                        state <= BOOT_DONE;
                end
                default: ;
            endcase

            if (take) begin
                req_valid <= 1'b1;  // request goes out the cycle after the byte
                next_addr <= next_addr + 1'b1;
            end else if (ack) begin
                req_valid <= 1'b0;
            end
        end
    end

    // write payload, byte copied to every lane
    always_ff @(posedge clk) begin
        if (take) begin
            req_addr  <= next_addr;
            req_wdata <= {4{flash_byte}};
            req_wstrb <= wstrb_t'(1) << next_addr[1:0];  // lane from addr[1:0]
        end
    end

    assign boot_req  = '{valid: req_valid, addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};
    assign boot_done = (state == BOOT_DONE);

endmodule

// File: src/iosys_regs.sv
`timescale 1ns/1ps
// apb slave with address decode, overlay and rom-load control registers,
// read mux for joystick, timers and id, and ram port arbitration
module iosys_regs import iosys_pkg::*; (
    input  logic     clk,
    input  logic     resetn,

    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,

    input  word_t    cycle_count,
    input  word_t    ms_count,
    input  joy_t     joy1,
    input  joy_t     joy2,

    // boot copier side
    input  mem_req_t boot_req,
    input  logic     boot_done,
    output logic     boot_ready,

    // rom streamer side
    input  logic     rom_busy,
    output word_t    rom_word,
    output logic     rom_word_we,
    output logic     rom_loading,
    output logic     overlay,

    // ram port
    output mem_req_t ram_req,
    input  logic     ram_ready,
    input  word_t    ram_rdata
);

    logic     access;
    logic     ram_sel;
    logic     overlay_sel;
    logic     rom_ctrl_sel;
    logic     rom_data_sel;
    logic     joy_sel;
    logic     time_sel;
    logic     cycle_sel;
    logic     id_sel;
    logic     pready;
    logic     wr_done;
    word_t    reg_rdata;
    mem_req_t apb_mem_req;
    logic     overlay_q;
    logic     rom_loading_q;

    assign access = apb_req.psel && apb_req.penable;

    // address decode
    assign ram_sel      = apb_req.paddr < RAM_TOP;
    assign overlay_sel  = apb_req.paddr == REG_BASE + OFF_OVERLAY;
    assign rom_ctrl_sel = apb_req.paddr == REG_BASE + OFF_ROM_CTRL;
    assign rom_data_sel = apb_req.paddr == REG_BASE + OFF_ROM_DATA;
    assign joy_sel      = apb_req.paddr == REG_BASE + OFF_JOY;
    assign time_sel     = apb_req.paddr == REG_BASE + OFF_TIME;
    assign cycle_sel    = apb_req.paddr == REG_BASE + OFF_CYCLE;
    assign id_sel       = apb_req.paddr == REG_BASE + OFF_ID;

    // nothing completes until the firmware copy is in ram
    always_comb begin
        pready = 1'b0;
        if (access && boot_done) begin
            if (ram_sel)
                pready = ram_ready;           // wait for the ram port
            else if (rom_data_sel && apb_req.pwrite)
                pready = !rom_busy;           // previous word still streaming
            else
                pready = 1'b1;
        end
    end

    assign wr_done = pready && apb_req.pwrite;

    always_comb begin
        reg_rdata = '0;  // unmapped and write-only registers
        if (joy_sel)
            reg_rdata = {4'b0, joy2, 4'b0, joy1};
        else if (time_sel)
            reg_rdata = ms_count;
        else if (cycle_sel)
            reg_rdata = cycle_count;
        else if (id_sel)
            reg_rdata = {16'b0, CORE_ID};
    end

    assign apb_rsp = '{pready: pready, prdata: ram_sel ? ram_rdata : reg_rdata};

    // overlay and rom-load control
    always_ff @(posedge clk) begin
        if (!resetn) begin
            overlay_q     <= 1'b1;  // menu visible at power up
            rom_loading_q <= 1'b0;
        end else if (wr_done) begin
            if (overlay_sel) begin
                case (apb_req.pwdata[25:24])
                    2'd1:    overlay_q <= 1'b1;
                    2'd2:    overlay_q <= 1'b0;
                    default: ;  // 0 and 3 keep the current state
                endcase
            end
            if (rom_ctrl_sel) begin
                if (apb_req.pwdata[7:0] == 8'd1)
                    rom_loading_q <= 1'b1;
                else if (apb_req.pwdata[7:0] == 8'd0)
                    rom_loading_q <= 1'b0;
            end
        end
    end

    assign overlay     = overlay_q;
    assign rom_loading = rom_loading_q;
    assign rom_word    = apb_req.pwdata;
    assign rom_word_we = wr_done && rom_data_sel;  // only when streamer is idle

    // apb ram window, held by the apb master until pready
    assign apb_mem_req = '{
        valid: access && ram_sel && boot_done,
        addr:  ram_addr_t'(apb_req.paddr),
        wdata: apb_req.pwdata,
        wstrb: apb_req.pwrite ? 4'hf : 4'h0
    };

    // boot copier owns the port until the copy is done
    assign ram_req    = boot_done ? apb_mem_req : boot_req;
    assign boot_ready = ram_ready && !boot_done;

endmodule

// File: src/iosys_top.sv
`timescale 1ns/1ps
// io subsystem top, register block with boot copier, rom streamer
// and uptime timer
module iosys_top import iosys_pkg::*; (
    input  logic     clk,
    input  logic     resetn,

    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,

    input  joy_t     joy1,
    input  joy_t     joy2,

    // flash byte stream, already deserialized
    input  byte_t    flash_byte,
    input  logic     flash_valid,
    output logic     flash_ready,

    // ram port
    input  logic     ram_busy,
    output mem_req_t ram_req,
    input  logic     ram_ready,
    input  word_t    ram_rdata,

    // console core side
    output byte_t    rom_byte,
    output logic     rom_valid,
    output logic     rom_loading,
    output logic     overlay
);

    word_t    cycle_count;
    word_t    ms_count;
    mem_req_t boot_req;
    logic     boot_done;
    logic     boot_ready;
    word_t    rom_word;
    logic     rom_word_we;
    logic     rom_busy;

    iosys_regs u_regs (
        .clk         (clk),
        .resetn      (resetn),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .cycle_count (cycle_count),
        .ms_count    (ms_count),
        .joy1        (joy1),
        .joy2        (joy2),
        .boot_req    (boot_req),
        .boot_done   (boot_done),
        .boot_ready  (boot_ready),
        .rom_busy    (rom_busy),
        .rom_word    (rom_word),
        .rom_word_we (rom_word_we),
        .rom_loading (rom_loading),
        .overlay     (overlay),
        .ram_req     (ram_req),
        .ram_ready   (ram_ready),
        .ram_rdata   (ram_rdata)
    );

    boot_copier u_boot (
        .clk         (clk),
        .resetn      (resetn),
        .ram_busy    (ram_busy),
        .flash_byte  (flash_byte),
        .flash_valid (flash_valid),
        .boot_ready  (boot_ready),
        .flash_ready (flash_ready),
        .boot_req    (boot_req),
        .boot_done   (boot_done)
    );

    rom_streamer u_rom (
        .clk         (clk),
        .resetn      (resetn),
        .rom_word    (rom_word),
        .rom_word_we (rom_word_we),
        .rom_byte    (rom_byte),
        .rom_valid   (rom_valid),
        .rom_busy    (rom_busy)
    );

    uptime_timer u_timer (
        .clk         (clk),
        .resetn      (resetn),
        .cycle_count (cycle_count),
        .ms_count    (ms_count)
    );

endmodule

// File: dv/iosys_tb.sv
`timescale 1ns/1ps
// io subsystem testbench with clock and reset, apb driver, flash source,
// ram model, stim file player, compare tasks and watchdog
module iosys_tb import iosys_pkg::*; ();

    localparam word_t SEED    = 32'hd89;
    localparam int    MAX_OPS = 64;
    localparam joy_t  JOY1    = 12'h5a3;
    localparam joy_t  JOY2    = 12'hc3e;

    logic     clk = 1'b0;
    logic     resetn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    joy_t     joy1;
    joy_t     joy2;
    byte_t    flash_byte;
    logic     flash_valid;
    logic     flash_ready;
    logic     ram_busy;
    mem_req_t ram_req;
    logic     ram_ready;
    word_t    ram_rdata;
    byte_t    rom_byte;
    logic     rom_valid;
    logic     rom_loading;
    logic     overlay;

    word_t    stim_mem [0:3*MAX_OPS-1];
    word_t    ram_mem [ram_addr_t];
    byte_t    flash_q[$];   // bytes accepted by the copier in order
    byte_t    rom_exp[$];
    byte_t    rom_seen[$];
    word_t    flash_rng;
    word_t    ram_rng;
    mem_req_t req_s;        // sampled at negedge
    logic     flash_ready_s;
    logic     rom_valid_q;
    logic     boot_phase;
    int       boot_writes;
    int       ram_wait;     // -1 while no request is being served
    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    int       watch_cycles = 0;

    iosys_top DUT (.*);

    always #5 clk = ~clk;

    function automatic word_t xorshift32(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_req(string name, mem_req_t got, mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic word_t ram_read(ram_addr_t a);
        ram_addr_t key;
        key = {a[22:2], 2'b00};
        return ram_mem.exists(key) ? ram_mem[key] : '0;
    endfunction

    task automatic ram_write(mem_req_t req);
        ram_addr_t key;
        word_t     merged;
        mem_req_t  exp;
        key    = {req.addr[22:2], 2'b00};
        merged = ram_read(req.addr);
        for (int b = 0; b < 4; b++)
            if (req.wstrb[b])
                merged[8*b +: 8] = req.wdata[8*b +: 8];
        ram_mem[key] = merged;
        if (boot_phase) begin
            if (boot_writes >= flash_q.size()) begin
                errors++;
                $display("boot write %0d arrived with no flash byte taken for it", boot_writes);
            end else begin
                // byte i goes to address i on the lane picked by its low address bits
                exp.valid = 1'b1;
                exp.addr  = ram_addr_t'(boot_writes);
                for (int b = 0; b < 4; b++) begin
                    exp.wdata[8*b +: 8] = flash_q[boot_writes];
                    exp.wstrb[b]        = (b == boot_writes % 4);
                end
                check_req($sformatf("ram_req boot write %0d", boot_writes), req, exp);
            end
            boot_writes++;
        end
    endtask

    // first apb completion closes the boot test
    task automatic close_boot_check();
        boot_phase = 1'b0;
        check_word("boot write count", word_t'(boot_writes), word_t'(BOOT_LEN));
        tests++;
        $display("test boot copy, %0d writes: %s", boot_writes, errors == 0 ? "ok" : "failed");
    endtask

    task automatic apb_xfer(input logic write, input word_t addr, input word_t wdata,
                            output word_t rdata);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready)
            @(negedge clk);
        rdata = apb_rsp.prdata;
        if (boot_phase)
            close_boot_check();
    endtask

    task automatic bus_idle();
        @(posedge clk);
        apb_req <= '0;
    endtask

    // outputs sampled half a cycle away from the driving edge
    always @(negedge clk) begin
        req_s = ram_req;
        flash_ready_s = flash_ready;
        // no flash byte is taken while ram is busy or a boot write is pending
        if (ram_busy || (boot_phase && ram_req.valid))
            check_word("flash_ready", word_t'(flash_ready), '0);
        if (rom_valid && !rom_valid_q)
            rom_seen.push_back(rom_byte);
        rom_valid_q = rom_valid;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            flash_valid <= 1'b0;
        end else begin
            if (flash_valid && flash_ready_s) begin  // byte taken at this edge
                flash_q.push_back(flash_byte);
                flash_rng = xorshift32(flash_rng);
                flash_byte <= flash_rng[7:0];
            end
            flash_valid <= 1'b1;
        end
    end

    // ram model answers after 0 to 3 cycles
    always @(posedge clk) begin
        if (!resetn) begin
            ram_ready <= 1'b0;
            ram_wait = -1;
        end else if (ram_ready) begin
            ram_ready <= 1'b0;  // handshake at this edge
            ram_wait = -1;
            if (req_s.wstrb != '0)
                ram_write(req_s);
        end else if (req_s.valid) begin
            if (ram_wait < 0) begin
                ram_rng = xorshift32(ram_rng);
                ram_wait = int'(ram_rng[1:0]);
            end
            if (ram_wait == 0) begin
                ram_ready <= 1'b1;
                ram_rdata <= ram_read(req_s.addr);
            end else begin
                ram_wait--;
            end
        end
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        word_t op;
        word_t addr;
        word_t data;
        word_t rd;
        word_t rd2;
        int    err0;
        int    d;
        int    e;
        int    n_ops;
        resetn      = 1'b0;
        apb_req     = '0;
        joy1        = JOY1;
        joy2        = JOY2;
        flash_rng   = xorshift32(SEED);
        ram_rng     = SEED;
        flash_byte  = flash_rng[7:0];
        flash_valid = 1'b0;
        ram_busy    = 1'b1;
        ram_ready   = 1'b0;
        ram_rdata   = '0;
        rom_valid_q = 1'b0;
        boot_phase  = 1'b1;
        boot_writes = 0;
        ram_wait    = -1;
        $readmemh("dv/iosys_stim.txt", stim_mem);
        n_ops = 0;
        while (n_ops < MAX_OPS && stim_mem[3*n_ops] != 32'hf)
            n_ops++;
        watch_cycles = n_ops * 40 + BOOT_LEN * 8;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        repeat (10) @(posedge clk);
        ram_busy <= 1'b0;  // external ram is up

        for (int i = 0; i < n_ops; i++) begin
            op   = stim_mem[3*i];
            addr = stim_mem[3*i+1];
            data = stim_mem[3*i+2];
            err0 = errors;
            case (op)
                1: begin
                    apb_xfer(1'b1, addr, data, rd);
                    bus_idle();
                end
                2: begin
                    apb_xfer(1'b0, addr, '0, rd);
                    bus_idle();
                    check_word($sformatf("prdata at 0x%h", addr), rd, data);
                end
                3: begin
                    apb_xfer(1'b0, addr, '0, rd);
                    apb_xfer(1'b0, addr, '0, rd2);
                    bus_idle();
                    check_word("cycle_count delta", rd2 - rd, data);
                end
                4: begin
                    apb_xfer(1'b0, addr, '0, rd);
                    bus_idle();
                    repeat (data) @(posedge clk);
                    apb_xfer(1'b0, addr, '0, rd2);
                    bus_idle();
                    d = int'(rd2 - rd);
                    e = int'(data) / TICKS_PER_MS;
                    checks++;
                    if (d < e - 1 || d > e + 1) begin
                        errors++;
                        $display("[ERROR] ms_count delta: got 0x%h, expected 0x%h +/- 1", d, e);
                    end
                end
                5: begin
                    for (int b = 0; b < 4; b++)
                        rom_exp.push_back(data[8*b +: 8]);
                    apb_xfer(1'b1, addr, data, rd);
                    bus_idle();
                end
                6: begin
                    while (rom_seen.size() < rom_exp.size())
                        @(negedge clk);
                    repeat (5) @(negedge clk);  // room for a stray extra strobe
                    if (rom_seen.size() != rom_exp.size()) begin
                        errors++;
                        $display("rom streamer sent %0d bytes where %0d were expected",
                                 rom_seen.size(), rom_exp.size());
                    end
                    for (int b = 0; b < rom_exp.size() && b < rom_seen.size(); b++)
                        check_byte($sformatf("rom_byte %0d", b), rom_seen[b], rom_exp[b]);
                    rom_exp.delete();
                    rom_seen.delete();
                end
                7: begin
                    @(negedge clk);
                    if (addr == 0)
                        check_word("overlay", word_t'(overlay), data);
                    else
                        check_word("rom_loading", word_t'(rom_loading), data);
                end
                8: repeat (data) @(posedge clk);
                default: begin
                    errors++;
                    $display("stim line %0d holds an unknown op code %0h", i, op);
                end
            endcase
            tests++;
            $display("test %0d op %0h addr 0x%h: %s", i, op, addr,
                     errors == err0 ? "ok" : "failed");
        end

        $display("done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: iosys_top.f
src/iosys_pkg.sv
src/uptime_timer.sv
src/rom_streamer.sv
src/boot_copier.sv
src/iosys_regs.sv
src/iosys_top.sv
dv/iosys_tb.sv

// File: run.sh
#!/bin/sh
# builds the io subsystem testbench with Verilator and runs it
# exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module iosys_tb -f iosys_top.f -o iosys_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/iosys_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// File: dv/iosys_stim.txt
// columns: op addr data, one hex word each; ops 1 write, 2 read and expect data,
// 3 two reads back to back, expect delta, 4 ms gap of data idle cycles,
// 5 rom word write, 6 rom byte check, 7 output check (0 overlay, 1 rom_loading), 8 idle, f end
2 02000060 00000002 // id, stalls until the boot copy is done
7 00000000 00000001
7 00000001 00000000
2 02000040 0c3e05a3 // joystick layout
2 02000070 00000000 // unmapped reg
2 01000000 00000000 // between ram window and regs
2 02000030 00000000 // rom ctrl reads zero
1 02000000 02000000 // overlay off
7 00000000 00000000
1 02000000 00000000 // 0 keeps
7 00000000 00000000
1 02000000 01000000 // overlay on
7 00000000 00000001
1 02000000 03000000 // 3 keeps
7 00000000 00000001
1 02000030 00000001
7 00000001 00000001
1 02000030 00000000
7 00000001 00000000
5 02000034 a1b2c3d4
6 00000000 00000000
5 02000034 11223344 // second write stalls on the first
5 02000034 55667788
6 00000000 00000000
3 02000054 00000002
4 02000050 0000012c // 300 idle cycles
1 00000100 deadbeef
2 00000100 deadbeef
1 00000204 12345678
8 00000000 00000005
2 00000204 12345678
2 00000100 deadbeef
f 00000000 00000000
